/* hdl/f8_pkg.sv */
package f8_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;
	typedef logic [23:0] inst_t;
	typedef logic [7:0] flags_t;
	typedef logic [1:0] byte_en_t;
	typedef logic reg_sel_t;

	// flag bit positions
	localparam int FLAG_C = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_Z = 3;

	typedef enum logic [7:0] {
		OP_SUB_XL_IMM = 8'h00,
		OP_ADD_XL_IMM = 8'h20,
		OP_OR_XL_IMM  = 8'h40,
		OP_AND_XL_IMM = 8'h50,
		OP_XOR_XL_IMM = 8'h60,
		OP_CP_XL_IMM  = 8'h70,
		OP_LD_XL_IMM  = 8'h80,
		OP_LD_XL_DIR  = 8'h81,
		OP_LD_IY_XL   = 8'h88,
		OP_JP_IMM     = 8'h90,
		OP_LDW_Y_IMM  = 8'hb0,
		OP_JR         = 8'hd0,
		OP_JRZ        = 8'hd2,
		OP_JRNZ       = 8'hd3,
		OP_JRC        = 8'hd4,
		OP_JRNC       = 8'hd5,
		OP_NOP        = 8'h08,
		OP_TRAP       = 8'h09
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS
	} alu_op_t;

	// opcode byte plus immediates
	function automatic logic [1:0] inst_len(input byte_t op);
		case (op)
			OP_SUB_XL_IMM, OP_ADD_XL_IMM, OP_OR_XL_IMM, OP_AND_XL_IMM,
			OP_XOR_XL_IMM, OP_CP_XL_IMM, OP_LD_XL_IMM,
			OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC:
				return 2'd2;
			OP_LDW_Y_IMM, OP_LD_XL_DIR, OP_JP_IMM:
				return 2'd3;
			default:
				return 2'd1;
		endcase
	endfunction

	// zero for anything that is not a relative jump
	function automatic logic branch_taken(input byte_t op, input flags_t f);
		case (op)
			OP_JR:   return 1'b1;
			OP_JRZ:  return f[FLAG_Z];
			OP_JRNZ: return !f[FLAG_Z];
			OP_JRC:  return f[FLAG_C];
			OP_JRNC: return !f[FLAG_C];
			default: return 1'b0;
		endcase
	endfunction

endpackage

/* hdl/f8_wb_if.sv */
`timescale 1ns/1ps

interface f8_wb_if import f8_pkg::*; ();
	byte_en_t reg_en;
	reg_sel_t reg_sel;
	word_t reg_data;

	// byte store request
	byte_en_t mem_en;
	word_t mem_addr;
	word_t mem_data;

	modport source (
		output reg_en, reg_sel, reg_data,
		output mem_en, mem_addr, mem_data
	);

	modport sink (
		input reg_en, reg_sel, reg_data,
		input mem_en, mem_addr, mem_data
	);
endinterface

/* hdl/f8_alu.sv */
`timescale 1ns/1ps

module f8_alu import f8_pkg::*; (
	input alu_op_t op,
	input byte_t a,
	input byte_t b,
	input logic c_in,
	output byte_t result,
	output logic c_out,
	output logic z_out,
	output logic n_out
);

	logic [8:0] sum;
	logic [8:0] diff;

	assign sum = {1'b0, a} + {1'b0, b};
	// bit 8 is the borrow, set when a < b
	assign diff = {1'b0, a} - {1'b0, b};

	always_comb
	begin
		c_out = c_in;
		case (op)
			ALU_ADD:
			begin
				result = sum[7:0];
				c_out = sum[8];
			end
			ALU_SUB:
			begin
				result = diff[7:0];
				c_out = diff[8];
			end
			ALU_AND:
				result = a & b;
			ALU_OR:
				result = a | b;
			ALU_XOR:
				result = a ^ b;
			default:
				result = b;
		endcase
	end

	assign z_out = (result == 8'h00);
	assign n_out = result[7];

endmodule

/* hdl/f8_fetch.sv */
`timescale 1ns/1ps

module f8_fetch import f8_pkg::*; #(
	parameter word_t RESET_VECTOR = 16'h4000
) (
	input logic clk,
	input logic reset,
	input inst_t iread_data,
	input flags_t next_flags,
	output word_t iread_addr,
	output word_t dread_addr,
	output inst_t inst
);

	word_t pc;
	word_t next_pc;
	byte_t opcode;
	logic [1:0] len;
	word_t disp;

	assign opcode = iread_data[7:0];
	assign len = inst_len(opcode);

	// jr displacement, sign extended
	assign disp = {{8{iread_data[15]}}, iread_data[15:8]};

	assign iread_addr = pc;

	always_comb
	begin
		if (opcode == OP_JP_IMM)
			next_pc = iread_data[23:8];
		// condition sees flags of the instruction now in execute
		else if (branch_taken(opcode, next_flags))
			next_pc = pc + disp;
		else
			next_pc = pc + {14'd0, len};
	end

	// data arrives one cycle later, in the execute cycle
	always_comb
	begin
		if (opcode == OP_LD_XL_DIR)
			dread_addr = iread_data[23:8];
		else
			dread_addr = '0;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= RESET_VECTOR;
			inst <= {16'h0000, OP_NOP};
		end
		else
		begin
			pc <= next_pc;
			inst <= iread_data;
		end
	end

	a_len_range: assert property (
		@(posedge clk) disable iff (reset)
		len inside {[2'd1:2'd3]}
	) else $error("fetch: bad instruction length %0d at %h", len, pc);

endmodule

/* hdl/f8_exec.sv */
`timescale 1ns/1ps

module f8_exec import f8_pkg::*; (
	input logic clk,
	input logic reset,
	input inst_t inst,
	input word_t dread_data,
	input word_t x,
	input word_t y,
	output flags_t next_flags,
	output logic trap,
	f8_wb_if.source wb
);

	byte_t opcode;
	byte_t imm;
	alu_op_t alu_op;
	byte_t alu_b;
	byte_t alu_result;
	logic c_out;
	logic z_out;
	logic n_out;
	logic arith;
	logic logic_op;
	flags_t flags;

	assign opcode = inst[7:0];
	assign imm = inst[15:8];

	always_comb
	begin
		alu_op = ALU_PASS;
		arith = 1'b0;
		logic_op = 1'b0;
		case (opcode)
			OP_ADD_XL_IMM:
			begin
				alu_op = ALU_ADD;
				arith = 1'b1;
			end
			// cp runs as sub without writing the result
			OP_SUB_XL_IMM, OP_CP_XL_IMM:
			begin
				alu_op = ALU_SUB;
				arith = 1'b1;
			end
			OP_AND_XL_IMM:
			begin
				alu_op = ALU_AND;
				logic_op = 1'b1;
			end
			OP_OR_XL_IMM:
			begin
				alu_op = ALU_OR;
				logic_op = 1'b1;
			end
			OP_XOR_XL_IMM:
			begin
				alu_op = ALU_XOR;
				logic_op = 1'b1;
			end
			default:
				alu_op = ALU_PASS;
		endcase
	end

	assign alu_b = (opcode == OP_LD_XL_DIR) ? dread_data[7:0] : imm;

	f8_alu u_alu (
		.op(alu_op),
		.a(x[7:0]),
		.b(alu_b),
		.c_in(flags[FLAG_C]),
		.result(alu_result),
		.c_out(c_out),
		.z_out(z_out),
		.n_out(n_out)
	);

	always_comb
	begin
		next_flags = '0;
		next_flags[FLAG_C] = arith ? c_out : flags[FLAG_C];
		next_flags[FLAG_N] = (arith || logic_op) ? n_out : flags[FLAG_N];
		next_flags[FLAG_Z] = (arith || logic_op) ? z_out : flags[FLAG_Z];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	always_comb
	begin
		wb.reg_en = 2'b00;
		wb.reg_sel = 1'b0;
		wb.reg_data = {8'h00, alu_result};
		wb.mem_en = 2'b00;
		wb.mem_addr = y;
		wb.mem_data = x;
		case (opcode)
			OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_AND_XL_IMM, OP_OR_XL_IMM,
			OP_XOR_XL_IMM, OP_LD_XL_IMM, OP_LD_XL_DIR:
				wb.reg_en = 2'b01;
			OP_LDW_Y_IMM:
			begin
				wb.reg_en = 2'b11;
				wb.reg_sel = 1'b1;
				wb.reg_data = inst[23:8];
			end
			OP_LD_IY_XL:
				wb.mem_en = 2'b01;
			default:
				wb.reg_en = 2'b00;
		endcase
	end

	assign trap = (opcode == OP_TRAP);

	a_one_write: assert property (
		@(posedge clk) disable iff (reset)
		!(wb.reg_en != 2'b00 && wb.mem_en != 2'b00)
	) else $error("exec: register and memory write in the same cycle");

endmodule

/* hdl/f8_writeback.sv */
`timescale 1ns/1ps

module f8_writeback import f8_pkg::*; (
	input logic clk,
	input logic reset,
	f8_wb_if.sink wb,
	output word_t x,
	output word_t y,
	output word_t dwrite_addr,
	output word_t dwrite_data,
	output byte_en_t dwrite_en
);

	// index 0 is X, 1 is Y
	word_t regs [2];

	assign x = regs[0];
	assign y = regs[1];

	always_ff @(posedge clk)
	begin
		for (int b = 0; b < 2; b++)
		begin
			if (wb.reg_en[b])
				regs[wb.reg_sel][b*8 +: 8] <= wb.reg_data[b*8 +: 8];
		end
	end

	// store goes out in the execute cycle
	assign dwrite_addr = wb.mem_addr;
	assign dwrite_data = wb.mem_data;
	assign dwrite_en = reset ? 2'b00 : wb.mem_en;

	// high lane alone never fires
	a_no_high_store: assert property (
		@(posedge clk) disable iff (reset)
		dwrite_en != 2'b10
	) else $error("writeback: high-byte-only store to %h", dwrite_addr);

endmodule

/* hdl/f8_core.sv */
`timescale 1ns/1ps

module f8_core import f8_pkg::*; #(
	parameter word_t RESET_VECTOR = 16'h4000
) (
	output word_t iread_addr,
	input inst_t iread_data,
	output word_t dread_addr,
	input word_t dread_data,
	output word_t dwrite_addr,
	output word_t dwrite_data,
	output byte_en_t dwrite_en,
	output logic trap,
	input logic clk,
	input logic reset
);

	inst_t inst;
	flags_t next_flags;
	word_t x;
	word_t y;

	f8_wb_if wb ();

	f8_fetch #(
		.RESET_VECTOR(RESET_VECTOR)
	) u_fetch (
		.clk(clk),
		.reset(reset),
		.iread_data(iread_data),
		.next_flags(next_flags),
		.iread_addr(iread_addr),
		.dread_addr(dread_addr),
		.inst(inst)
	);

	f8_exec u_exec (
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.dread_data(dread_data),
		.x(x),
		.y(y),
		.next_flags(next_flags),
		.trap(trap),
		.wb(wb.source)
	);

	f8_writeback u_writeback (
		.clk(clk),
		.reset(reset),
		.wb(wb.sink),
		.x(x),
		.y(y),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en)
	);

endmodule

/* verif/f8_tb_program.svh */
// program image at RESET_VECTOR and the stores it must make, in order

task automatic emit(input byte_t b);
	imem[load_pc] = b;
	load_pc = load_pc + 16'd1;
endtask

// little endian immediate
task automatic le16(input word_t w);
	emit(w[7:0]);
	emit(w[15:8]);
endtask

task automatic expect_store(input word_t addr, input byte_t data, input int test);
	exp_addr.push_back(addr);
	exp_data.push_back(data);
	exp_test.push_back(test);
endtask

function automatic byte_t alu_expect(input opcode_t op, input byte_t a, input byte_t b);
	case (op)
		OP_ADD_XL_IMM: return a + b;
		OP_SUB_XL_IMM: return a - b;
		OP_AND_XL_IMM: return a & b;
		OP_OR_XL_IMM:  return a | b;
		OP_XOR_XL_IMM: return a ^ b;
		// cp leaves xl alone
		default:       return a;
	endcase
endfunction

// zero on equal operands, borrow when a < b
function automatic logic predict_taken(input opcode_t jr, input byte_t a, input byte_t b);
	case (jr)
		OP_JRZ:  return a == b;
		OP_JRNZ: return a != b;
		OP_JRC:  return a < b;
		default: return a >= b;
	endcase
endfunction

task automatic build_program();
	opcode_t alu_ops [6];
	opcode_t jr_ops [4];
	byte_t a;
	byte_t b;
	word_t addr;
	word_t target;
	alu_ops = '{OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_AND_XL_IMM,
		OP_OR_XL_IMM, OP_XOR_XL_IMM, OP_CP_XL_IMM};
	jr_ops = '{OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC};
	load_pc = RESET_VECTOR;
	for (int i = 0; i < 12; i++)
	begin
		a = byte_t'($urandom);
		b = byte_t'($urandom);
		addr = word_t'(16'h1000 + i);
		emit(OP_LD_XL_IMM);
		emit(a);
		emit(alu_ops[i % 6]);
		emit(b);
		emit(OP_LDW_Y_IMM);
		le16(addr);
		emit(OP_LD_IY_XL);
		expect_store(addr, alu_expect(alu_ops[i % 6], a, b), 1);
	end
	// first four compare equal operands
	for (int i = 0; i < 8; i++)
	begin
		a = byte_t'($urandom);
		b = (i < 4) ? a : byte_t'($urandom);
		addr = word_t'(16'h1100 + i);
		emit(OP_LDW_Y_IMM);
		le16(addr);
		emit(OP_LD_XL_IMM);
		emit(a);
		emit((i % 2 == 1) ? OP_SUB_XL_IMM : OP_CP_XL_IMM);
		emit(b);
		// displacement counts from the jump itself
		emit(jr_ops[i % 4]);
		emit(8'd5);
		emit(OP_LD_XL_IMM);
		emit(8'haa);
		emit(OP_LD_IY_XL);
		if (!predict_taken(jr_ops[i % 4], a, b))
			expect_store(addr, 8'haa, 2);
	end
	for (int i = 0; i < 4; i++)
	begin
		a = byte_t'($urandom);
		addr = word_t'(16'h1200 + i);
		dmem[addr] = a;
		emit(OP_LD_XL_DIR);
		le16(addr);
		emit(OP_LDW_Y_IMM);
		le16(word_t'(16'h1300 + i));
		emit(OP_LD_IY_XL);
		expect_store(word_t'(16'h1300 + i), a, 3);
	end
	emit(OP_LD_XL_IMM);
	emit(8'h3c);
	// jp itself plus three skipped stores of four bytes
	target = load_pc + 16'd15;
	emit(OP_JP_IMM);
	le16(target);
	for (int i = 0; i < 3; i++)
	begin
		emit(OP_LDW_Y_IMM);
		le16(word_t'(16'h1400 + i));
		emit(OP_LD_IY_XL);
	end
	emit(OP_LDW_Y_IMM);
	le16(16'h1500);
	emit(OP_LD_XL_IMM);
	emit(8'hc3);
	emit(OP_LD_IY_XL);
	expect_store(16'h1500, 8'hc3, 4);
	trap_addr = load_pc;
	emit(OP_TRAP);
	for (int i = 0; i < 4; i++)
		emit(OP_NOP);
	prog_len = int'(load_pc - RESET_VECTOR);
endtask

/* verif/f8_core_tb.sv */
`timescale 1ns/1ps

module f8_core_tb import f8_pkg::*; ();

	// same as the core default
	localparam word_t RESET_VECTOR = 16'h4000;

	logic clk;
	logic reset;
	word_t iread_addr;
	inst_t iread_data;
	word_t dread_addr;
	word_t dread_data = '0;
	word_t dwrite_addr;
	word_t dwrite_data;
	byte_en_t dwrite_en;
	logic trap;

	byte_t imem [0:65535];
	byte_t dmem [0:65535];
	word_t load_pc;
	word_t trap_addr;
	int prog_len = 0;
	word_t exp_addr [$];
	byte_t exp_data [$];
	int exp_test [$];
	int cur_test = 0;
	int errors = 0;
	int test_errors [5] = '{default: 0};
	string test_names [5] = '{"reset", "alu", "branch", "direct load", "jump and trap"};
	int cycles = 0;
	logic reset_q = 1'b0;

	`include "f8_tb_program.svh"

	f8_core uut (
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.dread_addr(dread_addr),
		.dread_data(dread_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap),
		.clk(clk),
		.reset(reset)
	);

	// instruction bytes come back in the same cycle
	assign iread_data = {imem[iread_addr + 16'd2], imem[iread_addr + 16'd1], imem[iread_addr]};

	always @(posedge clk)
	begin
		dread_data <= #1 {dmem[dread_addr + 16'd1], dmem[dread_addr]};
		if (dwrite_en[0])
			dmem[dwrite_addr] = dwrite_data[7:0];
	end

	task automatic note_error(input string msg);
		errors++;
		test_errors[cur_test]++;
		$display("%s", msg);
	endtask

	task automatic close_test(input int t);
		$display("test %s: %s, %0d errors", test_names[t],
			(test_errors[t] == 0) ? "ok" : "bad", test_errors[t]);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		reset_q <= reset;
		cycles <= cycles + 1;
		if (cycles == 4 * prog_len + 50)
		begin
			$display("timeout: TRAP not reached after %0d cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	a_reset_quiet: assert property (@(posedge clk) reset_q |-> (dwrite_en == 2'b00 && !trap))
		else note_error($sformatf("MISMATCH at %0t: dwrite_en %b trap %b around reset",
			$time, dwrite_en, trap));

	a_reset_vector: assert property (@(posedge clk) (reset_q && !reset) |-> iread_addr == RESET_VECTOR)
		else note_error($sformatf("MISMATCH at %0t: first fetch at %h", $time, iread_addr));

	a_trap_timing: assert property (@(posedge clk) disable iff (reset)
		(iread_addr == trap_addr) |=> trap)
		else note_error($sformatf("MISMATCH at %0t: trap low after TRAP fetch", $time));

	a_trap_cause: assert property (@(posedge clk) disable iff (reset)
		trap |-> $past(iread_addr) == trap_addr)
		else note_error($sformatf("MISMATCH at %0t: trap high without TRAP fetch", $time));

	// stores are compared in program order
	always @(negedge clk)
	begin
		int done_test;
		if (!reset && dwrite_en != 2'b00)
		begin
			if (exp_addr.size() == 0)
				note_error($sformatf("unexpected store of %h to %h at %0t",
					dwrite_data[7:0], dwrite_addr, $time));
			else
			begin
				a_store: assert (dwrite_addr == exp_addr[0] && dwrite_data[7:0] == exp_data[0])
					else note_error($sformatf("MISMATCH at %0t: store %h to %h, expected %h to %h",
						$time, dwrite_data[7:0], dwrite_addr, exp_data[0], exp_addr[0]));
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
				done_test = exp_test.pop_front();
				if (exp_test.size() != 0 && exp_test[0] != done_test)
				begin
					while (cur_test < exp_test[0])
					begin
						close_test(cur_test);
						cur_test++;
					end
				end
			end
		end
	end

	initial
	begin
		int failed_tests;
		reset = 1'b1;
		void'($urandom(32'h1f449079));
		for (int a = 0; a < 65536; a++)
			dmem[a] = a[7:0] ^ a[15:8] ^ 8'h5a;
		build_program();
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		@(posedge clk);
		@(negedge clk);
		close_test(0);
		cur_test = 1;
		while (!trap)
			@(negedge clk);
		// let the trap timing check see the next edge
		@(posedge clk);
		@(negedge clk);
		if (exp_addr.size() != 0)
			note_error($sformatf("%0d expected stores never happened", exp_addr.size()));
		while (cur_test < 5)
		begin
			close_test(cur_test);
			cur_test++;
		end
		failed_tests = 0;
		for (int t = 0; t < 5; t++)
			if (test_errors[t] != 0)
				failed_tests++;
		$display("tests run 5, tests failed %0d, errors %0d", failed_tests, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* f8_core.f */
+incdir+verif
hdl/f8_pkg.sv
hdl/f8_wb_if.sv
hdl/f8_alu.sv
hdl/f8_fetch.sv
hdl/f8_exec.sv
hdl/f8_writeback.sv
hdl/f8_core.sv
verif/f8_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= f8_core_tb
FILELIST ?= f8_core.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
